// File: Bender.yml
package:
  name: smartnic_app_igr

sources:
  # Packages first
  - logic/nic_stream_pkg.sv
  - logic/p4_proc_pkg.sv
  # RTL
  - logic/match_table.sv
  - logic/igr_port_proc.sv
  - logic/smartnic_app_igr.sv
  # Testbench
  - target: simulation
    files:
      - verification/tb.sv

// File: build.f
logic/nic_stream_pkg.sv
logic/p4_proc_pkg.sv
logic/match_table.sv
logic/igr_port_proc.sv
logic/smartnic_app_igr.sv
verification/tb.sv

// File: logic/igr_port_proc.sv
`timescale 1ns/100ps
`default_nettype none

module igr_port_proc (
    input  logic                       core_clk,
    input  logic                       arst_n,
    input  nic_stream_pkg::timestamp_t timestamp,
    input  logic                       egr_flow_ctl,

    // Input stream
    input  logic                       in_tvalid,
    output logic                       in_tready,
    input  nic_stream_pkg::data_t      in_tdata,
    input  nic_stream_pkg::keep_t      in_tkeep,
    input  logic                       in_tlast,

    // Output stream
    output logic                       out_tvalid,
    input  logic                       out_tready,
    output nic_stream_pkg::data_t      out_tdata,
    output nic_stream_pkg::keep_t      out_tkeep,
    output logic                       out_tlast,
    output nic_stream_pkg::port_t      out_tdest,
    output nic_stream_pkg::timestamp_t out_ttimestamp,

    // Match table lookup
    output logic                       lookup_en,
    output p4_proc_pkg::key_t          lookup_key,
    input  p4_proc_pkg::action_t       result_action,
    input  nic_stream_pkg::port_t      result_port
);
    import nic_stream_pkg::*;
    import p4_proc_pkg::*;

    port_state_t state_q;
    port_state_t state_d;

    // First beat, held across the lookup cycle
    data_t      hold_data;
    keep_t      hold_keep;
    logic       hold_last;

    // Output register
    logic       out_valid_q;
    data_t      out_data_q;
    keep_t      out_keep_q;
    logic       out_last_q;

    // Per-packet metadata
    port_t      dest_q;
    timestamp_t ts_q;

    // Last input beat of the packet already taken
    logic       in_done_q;

    logic       in_xfer;
    logic       out_xfer;

    // ====================
    // Handshake
    // ====================

    assign out_tvalid = out_valid_q & ~egr_flow_ctl;
    assign out_xfer   = out_tvalid & out_tready;
    assign in_xfer    = in_tvalid & in_tready;

    always_comb begin
        case (state_q)
            ST_IDLE:   in_tready = ~egr_flow_ctl;
            ST_LOOKUP: in_tready = 1'b0;
            // Room when empty or draining this cycle
            ST_FWD:    in_tready = (~out_valid_q | out_xfer) & ~in_done_q;
            ST_DROP:   in_tready = 1'b1;
            default:   in_tready = 1'b0;
        endcase
    end

    // Key comes straight off the first beat
    assign lookup_en  = (state_q == ST_IDLE) & in_xfer;
    assign lookup_key = in_tdata[KEY_WID-1:0];

    // ====================
    // Next state
    // ====================

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (in_xfer) state_d = ST_LOOKUP;
            end
            ST_LOOKUP: begin
                if (result_action == ACT_FWD) state_d = ST_FWD;
                else if (hold_last)           state_d = ST_IDLE;
                else                          state_d = ST_DROP;
            end
            ST_FWD: begin
                if (out_xfer && out_last_q) state_d = ST_IDLE;
            end
            ST_DROP: begin
                if (in_xfer && in_tlast) state_d = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // Control state
    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= ST_IDLE;
            out_valid_q <= 1'b0;
            in_done_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_IDLE && in_xfer) begin
                in_done_q <= in_tlast;
            end else if (state_q == ST_FWD && in_xfer && in_tlast) begin
                in_done_q <= 1'b1;
            end
            if (state_q == ST_LOOKUP && result_action == ACT_FWD) begin
                out_valid_q <= 1'b1;
            end else if (state_q == ST_FWD && in_xfer) begin
                out_valid_q <= 1'b1;
            end else if (out_xfer) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    // ====================
    // Datapath
    // ====================

    always_ff @(posedge core_clk) begin
        if (state_q == ST_IDLE && in_xfer) begin
            hold_data <= in_tdata;
            hold_keep <= in_tkeep;
            hold_last <= in_tlast;
            ts_q      <= timestamp;
        end
        if (state_q == ST_LOOKUP) begin
            dest_q     <= result_port;
            out_data_q <= hold_data;
            out_keep_q <= hold_keep;
            out_last_q <= hold_last;
        end else if (state_q == ST_FWD && in_xfer) begin
            out_data_q <= in_tdata;
            out_keep_q <= in_tkeep;
            out_last_q <= in_tlast;
        end
    end

    assign out_tdata      = out_data_q;
    assign out_tkeep      = out_keep_q;
    assign out_tlast      = out_last_q;
    assign out_tdest      = dest_q;
    assign out_ttimestamp = ts_q;

endmodule : igr_port_proc

`default_nettype wire

// File: logic/match_table.sv
`timescale 1ns/100ps
`default_nettype none

module match_table (
    input  logic                  core_clk,
    input  logic                  arst_n,

    // Table programming
    input  logic                  wr_en,
    input  p4_proc_pkg::key_t     wr_addr,
    input  p4_proc_pkg::action_t  wr_action,
    input  nic_stream_pkg::port_t wr_port,

    // One lookup slot per port processor
    input  logic                  lookup_en     [nic_stream_pkg::NUM_PORTS],
    input  p4_proc_pkg::key_t     lookup_key    [nic_stream_pkg::NUM_PORTS],
    output p4_proc_pkg::action_t  result_action [nic_stream_pkg::NUM_PORTS],
    output nic_stream_pkg::port_t result_port   [nic_stream_pkg::NUM_PORTS]
);
    import nic_stream_pkg::*;
    import p4_proc_pkg::*;

    // ====================
    // Table storage
    // ====================

    // Action per entry
    action_t tbl_action [TABLE_DEPTH];

    // Egress port per entry, only meaningful for forward entries
    port_t   tbl_port   [TABLE_DEPTH];

    // All entries come out of reset as drop
    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < TABLE_DEPTH; i++) begin
                tbl_action[i] <= ACT_DROP;
            end
        end else if (wr_en) begin
            tbl_action[wr_addr] <= wr_action;
        end
    end

    always_ff @(posedge core_clk) begin
        if (wr_en) begin
            tbl_port[wr_addr] <= wr_port;
        end
    end

    // ====================
    // Lookup ports
    // ====================

    // Registered reads, one cycle after the strobe
    // A write to the same entry on the same edge is not seen yet
    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                result_action[p] <= ACT_DROP;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (lookup_en[p]) begin
                    result_action[p] <= tbl_action[lookup_key[p]];
                end
            end
        end
    end

    // Port result
    always_ff @(posedge core_clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (lookup_en[p]) begin
                result_port[p] <= tbl_port[lookup_key[p]];
            end
        end
    end

endmodule : match_table

`default_nettype wire

// File: logic/nic_stream_pkg.sv
`default_nettype none

package nic_stream_pkg;

    // ====================
    // Port count
    // ====================

    // Processing ports on the ingress side
    localparam int NUM_PORTS = 2;

    // Width of a port number
    localparam int PORT_WID = $clog2(NUM_PORTS);

    // ====================
    // Stream widths
    // ====================

    // One data beat
    localparam int DATA_WID = 64;

    // One keep bit per data byte
    localparam int KEEP_WID = DATA_WID / 8;

    // Free-running timestamp
    localparam int TIMESTAMP_WID = 64;

    // ====================
    // Stream field types
    // ====================

    typedef logic [PORT_WID-1:0]      port_t;
    typedef logic [DATA_WID-1:0]      data_t;
    typedef logic [KEEP_WID-1:0]      keep_t;
    typedef logic [TIMESTAMP_WID-1:0] timestamp_t;

endpackage : nic_stream_pkg

`default_nettype wire

// File: logic/p4_proc_pkg.sv
`default_nettype none

package p4_proc_pkg;

    // ====================
    // Match table sizing
    // ====================

    // Entries in the shared action table
    localparam int TABLE_DEPTH = 16;

    // Key indexes the table directly
    localparam int KEY_WID = $clog2(TABLE_DEPTH);

    typedef logic [KEY_WID-1:0] key_t;

    // Table actions, drop is the reset value
    typedef enum logic {
        ACT_DROP = 1'b0,
        ACT_FWD  = 1'b1
    } action_t;

    // ====================
    // Port processor FSM
    // ====================

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_LOOKUP = 2'd1,
        ST_FWD    = 2'd2,
        ST_DROP   = 2'd3
    } port_state_t;

endpackage : p4_proc_pkg

`default_nettype wire

// File: logic/smartnic_app_igr.sv
`timescale 1ns/100ps
`default_nettype none

module smartnic_app_igr (
    input  logic                       core_clk,
    input  logic                       arst_n,
    input  nic_stream_pkg::timestamp_t timestamp,
    input  logic [nic_stream_pkg::NUM_PORTS-1:0] egr_flow_ctl,

    // Table write
    input  logic                       tbl_wr_en,
    input  p4_proc_pkg::key_t          tbl_wr_addr,
    input  p4_proc_pkg::action_t       tbl_wr_action,
    input  nic_stream_pkg::port_t      tbl_wr_port,

    // Ingress streams
    input  logic                       in_tvalid      [nic_stream_pkg::NUM_PORTS],
    output logic                       in_tready      [nic_stream_pkg::NUM_PORTS],
    input  nic_stream_pkg::data_t      in_tdata       [nic_stream_pkg::NUM_PORTS],
    input  nic_stream_pkg::keep_t      in_tkeep       [nic_stream_pkg::NUM_PORTS],
    input  logic                       in_tlast       [nic_stream_pkg::NUM_PORTS],

    // Egress streams
    output logic                       out_tvalid     [nic_stream_pkg::NUM_PORTS],
    input  logic                       out_tready     [nic_stream_pkg::NUM_PORTS],
    output nic_stream_pkg::data_t      out_tdata      [nic_stream_pkg::NUM_PORTS],
    output nic_stream_pkg::keep_t      out_tkeep      [nic_stream_pkg::NUM_PORTS],
    output logic                       out_tlast      [nic_stream_pkg::NUM_PORTS],
    output nic_stream_pkg::port_t      out_tid        [nic_stream_pkg::NUM_PORTS],
    output nic_stream_pkg::port_t      out_tdest      [nic_stream_pkg::NUM_PORTS],
    output nic_stream_pkg::timestamp_t out_ttimestamp [nic_stream_pkg::NUM_PORTS]
);
    import nic_stream_pkg::*;
    import p4_proc_pkg::*;

    // Lookup paths between the processors and the table
    logic    lookup_en     [NUM_PORTS];
    key_t    lookup_key    [NUM_PORTS];
    action_t result_action [NUM_PORTS];
    port_t   result_port   [NUM_PORTS];

    // ====================
    // Shared match table
    // ====================

    match_table u_match_table (
        .core_clk      (core_clk),
        .arst_n        (arst_n),
        .wr_en         (tbl_wr_en),
        .wr_addr       (tbl_wr_addr),
        .wr_action     (tbl_wr_action),
        .wr_port       (tbl_wr_port),
        .lookup_en     (lookup_en),
        .lookup_key    (lookup_key),
        .result_action (result_action),
        .result_port   (result_port)
    );

    // ====================
    // Port processors
    // ====================

    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_port
        igr_port_proc u_igr_port_proc (
            .core_clk       (core_clk),
            .arst_n         (arst_n),
            .timestamp      (timestamp),
            .egr_flow_ctl   (egr_flow_ctl[g]),
            .in_tvalid      (in_tvalid[g]),
            .in_tready      (in_tready[g]),
            .in_tdata       (in_tdata[g]),
            .in_tkeep       (in_tkeep[g]),
            .in_tlast       (in_tlast[g]),
            .out_tvalid     (out_tvalid[g]),
            .out_tready     (out_tready[g]),
            .out_tdata      (out_tdata[g]),
            .out_tkeep      (out_tkeep[g]),
            .out_tlast      (out_tlast[g]),
            .out_tdest      (out_tdest[g]),
            .out_ttimestamp (out_ttimestamp[g]),
            .lookup_en      (lookup_en[g]),
            .lookup_key     (lookup_key[g]),
            .result_action  (result_action[g]),
            .result_port    (result_port[g])
        );

        // Ingress port number rides along as tid
        assign out_tid[g] = port_t'(g);
    end

endmodule : smartnic_app_igr

`default_nettype wire

// File: verification/igr_testdata.txt
# W key action port : table write, key in hex, action 1 forward or 0 drop
# P port beats key fwd dest : packet, fwd 1 expects it on its own port with tdest dest
# M mode : 0 free output, 1 random ready, 2 random ready and flow control
# D : wait until every expected beat has left
W 1 1 1
W 2 1 0
W 3 0 1
W 5 1 1
W a 1 0
W c 1 1
M 0
P 0 1 1 1 1
P 0 4 2 1 0
P 1 3 5 1 1
P 1 2 3 0 0
P 1 2 a 1 0
P 0 3 7 0 0
P 0 2 c 1 1
D
# Rewrite key 2 to port 1 and turn key 5 into a drop
W 2 1 1
W 5 0 0
P 0 2 2 1 1
P 1 5 2 1 1
P 1 1 5 0 0
P 1 3 1 1 1
D
# Random output back-pressure
M 1
P 0 6 1 1 1
P 1 4 a 1 0
P 0 3 3 0 0
P 0 5 c 1 1
P 1 8 2 1 1
P 1 1 a 1 0
D
# Back-pressure with flow control pauses
M 2
P 0 8 5 0 0
P 0 7 1 1 1
P 1 6 c 1 1
P 0 1 2 1 1
P 1 4 e 0 0
P 1 9 a 1 0
P 0 5 1 1 1
P 1 2 c 1 1
D
M 0
P 0 2 a 1 0
D

// File: verification/tb.sv
`timescale 1ns/100ps
`default_nettype none

module tb;
    import nic_stream_pkg::*;
    import p4_proc_pkg::*;

    localparam int XFER_TIMEOUT  = 200;
    localparam int DRAIN_TIMEOUT = 2000;

    // One expected output beat
    typedef struct packed {
        timestamp_t ts;
        data_t      data;
        keep_t      keep;
        logic       last;
        port_t      dest;
    } exp_t;

    logic                 core_clk;
    logic                 arst_n;
    timestamp_t           timestamp;
    logic [NUM_PORTS-1:0] egr_flow_ctl;
    logic                 tbl_wr_en;
    key_t                 tbl_wr_addr;
    action_t              tbl_wr_action;
    port_t                tbl_wr_port;

    logic       in_tvalid      [NUM_PORTS];
    logic       in_tready      [NUM_PORTS];
    data_t      in_tdata       [NUM_PORTS];
    keep_t      in_tkeep       [NUM_PORTS];
    logic       in_tlast       [NUM_PORTS];
    logic       out_tvalid     [NUM_PORTS];
    logic       out_tready     [NUM_PORTS];
    data_t      out_tdata      [NUM_PORTS];
    keep_t      out_tkeep      [NUM_PORTS];
    logic       out_tlast      [NUM_PORTS];
    port_t      out_tid        [NUM_PORTS];
    port_t      out_tdest      [NUM_PORTS];
    timestamp_t out_ttimestamp [NUM_PORTS];

    // Scoreboard state
    exp_t        exp_q0 [$];
    exp_t        exp_q1 [$];
    timestamp_t  last_ts [NUM_PORTS];
    int          errors;
    int          timeouts;
    int          mode;
    int          pkt_cnt;
    logic        started;
    logic [31:0] pay_lfsr;
    logic [31:0] bp_lfsr;
    logic [31:0] bp_r;

    smartnic_app_igr dut (
        .core_clk       (core_clk),
        .arst_n         (arst_n),
        .timestamp      (timestamp),
        .egr_flow_ctl   (egr_flow_ctl),
        .tbl_wr_en      (tbl_wr_en),
        .tbl_wr_addr    (tbl_wr_addr),
        .tbl_wr_action  (tbl_wr_action),
        .tbl_wr_port    (tbl_wr_port),
        .in_tvalid      (in_tvalid),
        .in_tready      (in_tready),
        .in_tdata       (in_tdata),
        .in_tkeep       (in_tkeep),
        .in_tlast       (in_tlast),
        .out_tvalid     (out_tvalid),
        .out_tready     (out_tready),
        .out_tdata      (out_tdata),
        .out_tkeep      (out_tkeep),
        .out_tlast      (out_tlast),
        .out_tid        (out_tid),
        .out_tdest      (out_tdest),
        .out_ttimestamp (out_ttimestamp)
    );

    // ====================
    // Helpers
    // ====================

    // One step of a 32-bit Galois LFSR
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, inout logic [31:0] st, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v  = {v[30:0], st[0]};
            st = lfsr_step(st);
        end
    endtask

    task automatic end_run();
        $display("Checks done with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    task automatic check_val(input string name, input int p, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
        assert (exp_v === act_v) else begin
            $display("ERR %0t %s[%0d] expected %h actual %h", $time, name, p, exp_v, act_v);
            errors++;
        end
    endtask

    // ====================
    // Output monitor
    // ====================

    task automatic check_port(input int p);
        exp_t e;
        logic have;
        // Quiet outputs before the first packet and under flow control
        if (!started || egr_flow_ctl[p]) begin
            check_val("out_tvalid", p, 64'd0, 64'(out_tvalid[p]));
        end
        if (out_tvalid[p] && out_tready[p]) begin
            have = (p == 0) ? (exp_q0.size() > 0) : (exp_q1.size() > 0);
            assert (have) else begin
                $display("Port %0d sent a beat that no packet expects at %0t", p, $time);
                errors++;
            end
            if (have) begin
                e = (p == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
                check_val("out_tdata", p, e.data, out_tdata[p]);
                check_val("out_tkeep", p, 64'(e.keep), 64'(out_tkeep[p]));
                check_val("out_tlast", p, 64'(e.last), 64'(out_tlast[p]));
                check_val("out_tid", p, 64'(p), 64'(out_tid[p]));
                check_val("out_tdest", p, 64'(e.dest), 64'(out_tdest[p]));
                check_val("out_ttimestamp", p, e.ts, out_ttimestamp[p]);
                assert (out_ttimestamp[p] >= last_ts[p]) else begin
                    $display("ERR %0t out_ttimestamp[%0d] expected >= %h actual %h",
                             $time, p, last_ts[p], out_ttimestamp[p]);
                    errors++;
                end
                last_ts[p] = out_ttimestamp[p];
            end
        end
    endtask

    always @(negedge core_clk) begin
        if (arst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                check_port(p);
            end
        end
    end

    // ====================
    // Stimulus
    // ====================

    initial begin
        core_clk = 1'b0;
        forever #5 core_clk = ~core_clk;
    end

    // Timestamp counter, output ready and flow control
    always @(posedge core_clk) begin
        int cur_mode;
        // Mode as it stood at the edge
        cur_mode = mode;
        #1;
        timestamp = timestamp + 1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (cur_mode == 0) begin
                out_tready[p]   = 1'b1;
                egr_flow_ctl[p] = 1'b0;
            end else begin
                take_bits(2, bp_lfsr, bp_r);
                out_tready[p] = |bp_r[1:0];
                egr_flow_ctl[p] = 1'b0;
                if (cur_mode == 2) begin
                    take_bits(3, bp_lfsr, bp_r);
                    egr_flow_ctl[p] = &bp_r[2:0];
                end
            end
        end
    end

    task automatic write_table(input key_t key, input int act, input int port);
        tbl_wr_en     = 1'b1;
        tbl_wr_addr   = key;
        tbl_wr_action = (act != 0) ? ACT_FWD : ACT_DROP;
        tbl_wr_port   = port_t'(port);
        @(posedge core_clk);
        #1;
        tbl_wr_en = 1'b0;
    endtask

    task automatic send_packet(input int p, input int beats, input key_t key, input int fwd,
                               input int dest);
        exp_t        e;
        data_t       d;
        keep_t       k;
        logic [31:0] r0;
        logic [31:0] r1;
        timestamp_t  ts0;
        logic        rdy;
        int          wait_cnt;
        started = 1'b1;
        pkt_cnt++;
        ts0 = '0;
        for (int b = 0; b < beats; b++) begin
            if (b == 0) begin
                d = {32'(pkt_cnt), 28'h0, key};
            end else begin
                take_bits(32, pay_lfsr, r0);
                take_bits(32, pay_lfsr, r1);
                d = {r0, r1};
            end
            k = 8'hff;
            if (b == beats - 1) begin
                take_bits(3, pay_lfsr, r0);
                k = 8'hff >> r0[2:0];
            end
            in_tvalid[p] = 1'b1;
            in_tdata[p]  = d;
            in_tkeep[p]  = k;
            in_tlast[p]  = (b == beats - 1);
            rdy = 1'b0;
            wait_cnt = 0;
            // Ready and timestamp are stable at the falling edge
            while (!rdy && wait_cnt < XFER_TIMEOUT) begin
                @(negedge core_clk);
                rdy = in_tready[p];
                if (b == 0) ts0 = timestamp;
                @(posedge core_clk);
                #1;
                wait_cnt++;
            end
            if (!rdy) begin
                $display("Timeout: port %0d never accepted beat %0d of packet %0d",
                         p, b, pkt_cnt);
                timeouts++;
                in_tvalid[p] = 1'b0;
                return;
            end
            if (fwd != 0) begin
                e.ts   = ts0;
                e.data = d;
                e.keep = k;
                e.last = (b == beats - 1);
                e.dest = port_t'(dest);
                if (p == 0) exp_q0.push_back(e);
                else        exp_q1.push_back(e);
            end
        end
        in_tvalid[p] = 1'b0;
        in_tlast[p]  = 1'b0;
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while ((exp_q0.size() != 0 || exp_q1.size() != 0) && cnt < DRAIN_TIMEOUT) begin
            @(posedge core_clk);
            #1;
            cnt++;
        end
        if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            $display("Timeout: outputs did not drain, %0d and %0d beats still expected",
                     exp_q0.size(), exp_q1.size());
            timeouts++;
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        int                fd;
        int                n;
        int                a0;
        int                a1;
        int                a2;
        int                a3;
        int                a4;
        logic [8*8-1:0]    cmd;
        logic [8*128-1:0]  line;
        errors = 0;
        timeouts = 0;
        mode = 0;
        pkt_cnt = 0;
        started = 1'b0;
        pay_lfsr = 32'h4726_42d0;
        bp_lfsr = 32'h4726_42d0;
        timestamp = '0;
        egr_flow_ctl = '0;
        tbl_wr_en = 1'b0;
        tbl_wr_addr = '0;
        tbl_wr_action = ACT_DROP;
        tbl_wr_port = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_tvalid[p]  = 1'b0;
            in_tdata[p]   = '0;
            in_tkeep[p]   = '0;
            in_tlast[p]   = 1'b0;
            out_tready[p] = 1'b1;
            last_ts[p]    = '0;
        end
        arst_n = 1'b0;
        repeat (4) @(posedge core_clk);
        #1;
        arst_n = 1'b1;

        fd = $fopen("verification/igr_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            errors++;
        end else begin
            while (!$feof(fd) && timeouts == 0) begin
                n = $fscanf(fd, " %s", cmd);
                if (n == 1) begin
                    if (cmd == "#") begin
                        n = $fgets(line, fd);
                    end else if (cmd == "W") begin
                        n = $fscanf(fd, "%h %d %d", a0, a1, a2);
                        write_table(key_t'(a0), a1, a2);
                    end else if (cmd == "P") begin
                        n = $fscanf(fd, "%d %d %h %d %d", a0, a1, a2, a3, a4);
                        send_packet(a0, a1, key_t'(a2), a3, a4);
                    end else if (cmd == "M") begin
                        n = $fscanf(fd, "%d", a0);
                        mode = a0;
                    end else if (cmd == "D") begin
                        wait_drain();
                    end else begin
                        $display("Unknown command in the test data file");
                        errors++;
                    end
                end
            end
            $fclose(fd);
            if (timeouts == 0) begin
                wait_drain();
            end
            // A few idle cycles to catch stray beats
            repeat (10) @(posedge core_clk);
        end
        end_run();
    end

endmodule : tb

`default_nettype wire
